// File: flist.f
source/fabric_pkg.sv
source/fabric_cmd_if.sv
source/fabric_result_if.sv
source/fabric_req_decode.sv
source/fabric_mem_execute.sv
source/fabric_rsp_stage.sv
source/fabric_mem_top.sv
verification/fabric_mem_chk.sv
verification/fabric_mem_tb.sv

// File: verification/fabric_mem_tb.sv
/* Testbench for the fabric memory target. Random requests run against a byte model,
   and an in-order scoreboard checks every response. */
`default_nettype none

module fabric_mem_tb;

  localparam int unsigned num_random  = 600;
  // Full-word writes that cover the small window and the top of memory
  localparam int unsigned num_preload = 41;
  localparam int unsigned cycle_limit = (num_random + num_preload) * 12;

  typedef struct packed {
    logic [fabric_pkg::data_w-1:0] rdata;
    logic [fabric_pkg::code_w-1:0] code;
    logic [fabric_pkg::id_w-1:0]   id;
  } expect_t;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  req_valid;
  logic [fabric_pkg::addr_w-1:0]         req_addr;
  logic [fabric_pkg::data_w-1:0]         req_wdata;
  logic [fabric_pkg::bytes_per_word-1:0] req_wstrb;
  logic [fabric_pkg::op_w-1:0]           req_op;
  logic [fabric_pkg::id_w-1:0]           req_id;
  logic                                  req_ready;
  logic                                  rsp_valid;
  logic [fabric_pkg::data_w-1:0]         rsp_rdata;
  logic [fabric_pkg::code_w-1:0]         rsp_code;
  logic [fabric_pkg::id_w-1:0]           rsp_id;
  logic                                  rsp_ready;

  logic [7:0]  model_mem [fabric_pkg::mem_bytes];
  expect_t     exp_q [$];
  int unsigned cycle_count;
  int unsigned seed;

  fabric_mem_top fabric_mem_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_wstrb (req_wstrb),
    .req_op    (req_op),
    .req_id    (req_id),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_code  (rsp_code),
    .rsp_id    (rsp_id),
    .rsp_ready (rsp_ready)
  );

  always #10 clk = ~clk;

  // Requester takes a response about 70% of the cycles
  always @(negedge clk) begin
    rsp_ready = ($urandom_range(0, 9) < 7);
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // Applies one accepted request to the byte model and queues its expected response
  task automatic model_request(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb, input logic [7:0] op,
                               input logic [3:0] id);
    expect_t     e;
    logic [32:0] end_addr;
    logic [15:0] old_half;
    e.rdata  = '0;
    e.code   = fabric_pkg::resp_ok;
    e.id     = id;
    end_addr = {1'b0, addr} + ((op == fabric_pkg::op_atomic) ? 33'd2 : 33'd4);
    if (end_addr > fabric_pkg::mem_bytes) begin
      e.code = fabric_pkg::resp_decode_err;
    end else if (op == fabric_pkg::op_read) begin
      for (int b = 0; b < 4; b++) e.rdata[b*8 +: 8] = model_mem[addr + b];
    end else if (op == fabric_pkg::op_write) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) model_mem[addr + b] = wdata[b*8 +: 8];
      end
    end else if (op == fabric_pkg::op_atomic) begin
      old_half        = {model_mem[addr + 1], model_mem[addr]};
      e.rdata[15:0]   = old_half;
      if (old_half == wdata[15:0]) begin
        e.rdata[31]         = 1'b1;
        model_mem[addr]     = wdata[23:16];
        model_mem[addr + 1] = wdata[31:24];
      end
    end else begin
      e.code = fabric_pkg::resp_access_fault;
    end
    exp_q.push_back(e);
  endtask

  task automatic check_response();
    expect_t head;
    assert (exp_q.size() != 0)
      else report_failure("A response arrived with no request outstanding");
    head = exp_q.pop_front();
    assert (rsp_id === head.id)
      else report_failure($sformatf("Mismatch rsp_id: got %h expected %h", rsp_id, head.id));
    assert (rsp_code === head.code)
      else report_failure($sformatf("Mismatch rsp_code: got %h expected %h", rsp_code,
                                    head.code));
    assert (rsp_rdata === head.rdata)
      else report_failure($sformatf("Mismatch rsp_rdata: got %h expected %h", rsp_rdata,
                                    head.rdata));
  endtask

  // Transfers are judged on the values present at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        report_failure("Timeout: requests were still unanswered at the cycle limit");
      end
      if (rsp_valid && rsp_ready) check_response();
      if (req_valid && req_ready) model_request(req_addr, req_wdata, req_wstrb, req_op, req_id);
    end
  end

  // Called at a falling edge, returns at the falling edge after the transfer
  task automatic send_request(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, input logic [7:0] op);
    req_valid = 1'b1;
    req_addr  = addr;
    req_wdata = wdata;
    req_wstrb = wstrb;
    req_op    = op;
    req_id    = 4'($urandom_range(0, 15));
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic random_request();
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [7:0]  op;
    int unsigned pick;
    pick = $urandom_range(0, 19);
    if (pick < 16) addr = $urandom_range(0, 127);
    else if (pick < 19) addr = $urandom_range(4080, 4103);
    else addr = $urandom | 32'h8000_0000;
    pick = $urandom_range(0, 19);
    if (pick < 7) op = fabric_pkg::op_read;
    else if (pick < 13) op = fabric_pkg::op_write;
    else if (pick < 18) op = fabric_pkg::op_atomic;
    else op = 8'($urandom_range(3, 255));
    wdata = $urandom;
    // Half of the in-range swaps expect the current halfword so that they succeed
    if (op == fabric_pkg::op_atomic && addr < fabric_pkg::mem_bytes - 1 &&
        $urandom_range(0, 1) == 1) begin
      wdata[15:0] = {model_mem[addr + 1], model_mem[addr]};
    end
    send_request(addr, wdata, 4'($urandom_range(0, 15)), op);
  endtask

  initial begin
    seed        = 32'hf7de_ba58;
    void'($urandom(seed));
    clk         = 1'b0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    req_wstrb   = '0;
    req_op      = '0;
    req_id      = '0;
    rsp_ready   = 1'b0;
    cycle_count = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Memory is not reset, so every byte that later reads can reach is written first
    for (int a = 0; a <= 128; a += 4) send_request(a, $urandom, 4'hf, fabric_pkg::op_write);
    for (int a = 4064; a < 4096; a += 4) send_request(a, $urandom, 4'hf, fabric_pkg::op_write);

    for (int i = 0; i < num_random; i++) begin
      if ($urandom_range(0, 3) == 0) repeat ($urandom_range(1, 3)) @(negedge clk);
      random_request();
    end

    while (exp_q.size() != 0) @(negedge clk);
    repeat (8) @(negedge clk);
    assert (!rsp_valid)
      else report_failure("A response appeared after all requests were answered");

    $display("=== PASS ===");
    $finish;
  end

endmodule : fabric_mem_tb

`default_nettype wire

// File: verification/fabric_mem_chk.sv
/* Handshake assertions for the fabric memory target, bound into its top level. */
`default_nettype none

module fabric_mem_chk (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          req_valid,
  input logic                          req_ready,
  input logic                          rsp_valid,
  input logic                          rsp_ready,
  input logic [fabric_pkg::data_w-1:0] rsp_rdata,
  input logic [fabric_pkg::code_w-1:0] rsp_code,
  input logic [fabric_pkg::id_w-1:0]   rsp_id
);

  // Accepted requests not yet answered
  logic [2:0] in_flight;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + 3'(req_valid && req_ready) - 3'(rsp_valid && rsp_ready);
    end
  end

  rsp_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=>
      rsp_valid && $stable(rsp_rdata) && $stable(rsp_code) && $stable(rsp_id))
    else $error("Response dropped or changed while waiting for rsp_ready");

  rsp_idle_in_reset : assert property (@(posedge clk) !rst_n |-> !rsp_valid)
    else $error("rsp_valid is high during reset");

  in_flight_limit : assert property (@(posedge clk) disable iff (!rst_n) in_flight <= 3'd2)
    else $error("More than two requests are in flight");

endmodule : fabric_mem_chk

bind fabric_mem_top fabric_mem_chk fabric_mem_chk_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp_rdata (rsp_rdata),
  .rsp_code  (rsp_code),
  .rsp_id    (rsp_id)
);

`default_nettype wire

// File: source/fabric_mem_top.sv
/* Fabric memory target top level: decode, execute and response stages
   joined by the command and result channels. */
`default_nettype none

module fabric_mem_top (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  req_valid,
  input  logic [fabric_pkg::addr_w-1:0]         req_addr,
  input  logic [fabric_pkg::data_w-1:0]         req_wdata,
  input  logic [fabric_pkg::bytes_per_word-1:0] req_wstrb,
  input  logic [fabric_pkg::op_w-1:0]           req_op,
  input  logic [fabric_pkg::id_w-1:0]           req_id,
  output logic                                  req_ready,

  output logic                                  rsp_valid,
  output logic [fabric_pkg::data_w-1:0]         rsp_rdata,
  output logic [fabric_pkg::code_w-1:0]         rsp_code,
  output logic [fabric_pkg::id_w-1:0]           rsp_id,
  input  logic                                  rsp_ready
);

  fabric_cmd_if    cmd_bus ();
  fabric_result_if res_bus ();

  fabric_req_decode fabric_req_decode_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_wstrb (req_wstrb),
    .req_op    (req_op),
    .req_id    (req_id),
    .req_ready (req_ready),
    .cmd       (cmd_bus.source)
  );

  fabric_mem_execute fabric_mem_execute_inst (
    .clk (clk),
    .cmd (cmd_bus.sink),
    .res (res_bus.source)
  );

  fabric_rsp_stage fabric_rsp_stage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .res       (res_bus.sink),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_code  (rsp_code),
    .rsp_id    (rsp_id),
    .rsp_ready (rsp_ready)
  );

endmodule : fabric_mem_top

`default_nettype wire

// File: source/fabric_rsp_stage.sv
/* Response register: captures one finished result and holds it on the fabric
   until the requester takes it. */
`default_nettype none

module fabric_rsp_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  fabric_result_if.sink                 res,
  output logic                          rsp_valid,
  output logic [fabric_pkg::data_w-1:0] rsp_rdata,
  output logic [fabric_pkg::code_w-1:0] rsp_code,
  output logic [fabric_pkg::id_w-1:0]   rsp_id,
  input  logic                          rsp_ready
);

  logic                          valid_q;
  logic [fabric_pkg::data_w-1:0] rdata_q;
  logic [fabric_pkg::code_w-1:0] code_q;
  logic [fabric_pkg::id_w-1:0]   id_q;
  logic                          load;

  // Empty, or the held response drains in this same cycle
  assign res.ready = !valid_q || rsp_ready;
  assign load      = res.valid && res.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (rsp_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rdata_q <= res.rdata;
      code_q  <= res.code;
      id_q    <= res.id;
    end
  end

  assign rsp_valid = valid_q;
  assign rsp_rdata = rdata_q;
  assign rsp_code  = code_q;
  assign rsp_id    = id_q;

endmodule : fabric_rsp_stage

`default_nettype wire

// File: source/fabric_mem_execute.sv
/* Execute stage: owns the byte memory, reads it combinationally and commits
   writes and successful swaps when the command moves into the response register. */
`default_nettype none

module fabric_mem_execute (
  input  logic            clk,
  fabric_cmd_if.sink      cmd,
  fabric_result_if.source res
);

  logic [7:0] mem [fabric_pkg::mem_bytes];

  logic [fabric_pkg::mem_addr_w-1:0] base;
  logic [fabric_pkg::data_w-1:0]     rd_word;
  logic [15:0]                       old_half;
  logic                              cas_hit;
  logic                              cmd_fire;

  // Decode has already checked bounds, so the low bits index the array directly
  assign base = cmd.addr[fabric_pkg::mem_addr_w-1:0];

  // Little-endian word assembly
  always_comb begin
    for (int b = 0; b < fabric_pkg::bytes_per_word; b++) begin
      rd_word[b*8 +: 8] = mem[base + fabric_pkg::mem_addr_w'(b)];
    end
  end

  assign old_half = rd_word[15:0];
  assign cas_hit  = old_half == cmd.wdata.cas.expected;

  // No buffering here, so the stage stalls exactly when the response register does
  assign cmd.ready = res.ready;
  assign cmd_fire  = cmd.valid && cmd.ready;

  always_comb begin
    case (cmd.kind)
      fabric_pkg::kind_read: begin
        res.rdata = rd_word;
      end
      fabric_pkg::kind_cas: begin
        res.rdata        = '0;
        res.rdata[15:0]  = old_half;
        res.rdata[31]    = cas_hit;
      end
      default: begin
        res.rdata = '0;
      end
    endcase
  end

  assign res.valid = cmd.valid;
  assign res.code  = cmd.code;
  assign res.id    = cmd.id;

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      case (cmd.kind)
        fabric_pkg::kind_write: begin
          for (int b = 0; b < fabric_pkg::bytes_per_word; b++) begin
            if (cmd.wstrb[b]) begin
              mem[base + fabric_pkg::mem_addr_w'(b)] <= cmd.wdata.word[b*8 +: 8];
            end
          end
        end
        fabric_pkg::kind_cas: begin
          // Only a matching compare stores the desired halfword
          if (cas_hit) begin
            mem[base]      <= cmd.wdata.cas.desired[7:0];
            mem[base + 1'b1] <= cmd.wdata.cas.desired[15:8];
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule : fabric_mem_execute

`default_nettype wire

// File: source/fabric_req_decode.sv
/* Request stage: accepts fabric requests, classifies and bounds-checks them,
   and holds one decoded command for the execute stage. */
`default_nettype none

module fabric_req_decode (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  req_valid,
  input  logic [fabric_pkg::addr_w-1:0]         req_addr,
  input  logic [fabric_pkg::data_w-1:0]         req_wdata,
  input  logic [fabric_pkg::bytes_per_word-1:0] req_wstrb,
  input  logic [fabric_pkg::op_w-1:0]           req_op,
  input  logic [fabric_pkg::id_w-1:0]           req_id,
  output logic                                  req_ready,
  fabric_cmd_if.source                          cmd
);

  logic                                  valid_q;
  fabric_pkg::fabric_kind_e              kind_q;
  logic [fabric_pkg::addr_w-1:0]         addr_q;
  fabric_pkg::fabric_wdata_u             wdata_q;
  logic [fabric_pkg::bytes_per_word-1:0] wstrb_q;
  logic [fabric_pkg::id_w-1:0]           id_q;
  logic [fabric_pkg::code_w-1:0]         code_q;

  fabric_pkg::fabric_kind_e      kind_d;
  logic [fabric_pkg::code_w-1:0] code_d;
  // One extra bit so the end address cannot wrap
  logic [fabric_pkg::addr_w:0]   end_addr;
  logic                          in_range;
  logic                          req_fire;

  // Free slot, or the held command leaves this cycle
  assign req_ready = !valid_q || cmd.ready;
  assign req_fire  = req_valid && req_ready;

  always_comb begin
    if (req_op == fabric_pkg::op_atomic) begin
      end_addr = {1'b0, req_addr} + 2;
    end else begin
      end_addr = {1'b0, req_addr} + fabric_pkg::bytes_per_word;
    end
    in_range = end_addr <= fabric_pkg::mem_bytes;

    kind_d = fabric_pkg::kind_error;
    code_d = fabric_pkg::resp_ok;
    if (!in_range) begin
      code_d = fabric_pkg::resp_decode_err;
    end else begin
      case (req_op)
        fabric_pkg::op_read:   kind_d = fabric_pkg::kind_read;
        fabric_pkg::op_write:  kind_d = fabric_pkg::kind_write;
        fabric_pkg::op_atomic: kind_d = fabric_pkg::kind_cas;
        default:               code_d = fabric_pkg::resp_access_fault;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (req_fire) begin
      valid_q <= 1'b1;
    end else if (cmd.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      kind_q       <= kind_d;
      addr_q       <= req_addr;
      wdata_q.word <= req_wdata;
      wstrb_q      <= req_wstrb;
      id_q         <= req_id;
      code_q       <= code_d;
    end
  end

  assign cmd.valid = valid_q;
  assign cmd.kind  = kind_q;
  assign cmd.addr  = addr_q;
  assign cmd.wdata = wdata_q;
  assign cmd.wstrb = wstrb_q;
  assign cmd.id    = id_q;
  assign cmd.code  = code_q;

endmodule : fabric_req_decode

`default_nettype wire

// File: source/fabric_result_if.sv
/* Finished result channel from the memory execute stage to the response register. */
`default_nettype none

interface fabric_result_if;

  logic                          valid;
  logic                          ready;
  logic [fabric_pkg::data_w-1:0] rdata;
  logic [fabric_pkg::code_w-1:0] code;
  logic [fabric_pkg::id_w-1:0]   id;

  modport source (
    output valid,
    output rdata,
    output code,
    output id,
    input  ready
  );

  modport sink (
    input  valid,
    input  rdata,
    input  code,
    input  id,
    output ready
  );

endinterface : fabric_result_if

`default_nettype wire

// File: source/fabric_cmd_if.sv
/* Decoded command channel from the request decode stage to the memory execute stage. */
`default_nettype none

interface fabric_cmd_if;

  logic                                  valid;
  logic                                  ready;
  fabric_pkg::fabric_kind_e              kind;
  logic [fabric_pkg::addr_w-1:0]         addr;
  fabric_pkg::fabric_wdata_u             wdata;
  logic [fabric_pkg::bytes_per_word-1:0] wstrb;
  logic [fabric_pkg::id_w-1:0]           id;
  // Response code for the command, resp_ok unless decode flagged an error
  logic [fabric_pkg::code_w-1:0]         code;

  modport source (
    output valid,
    output kind,
    output addr,
    output wdata,
    output wstrb,
    output id,
    output code,
    input  ready
  );

  modport sink (
    input  valid,
    input  kind,
    input  addr,
    input  wdata,
    input  wstrb,
    input  id,
    input  code,
    output ready
  );

endinterface : fabric_cmd_if

`default_nettype wire

// File: source/fabric_pkg.sv
/* Shared widths, opcodes, response codes and command types for the fabric memory target.
   Every design file refers to these by scoped name. */
`default_nettype none

package fabric_pkg;

  // Fabric field widths
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;
  localparam int unsigned id_w   = 4;
  localparam int unsigned op_w   = 8;
  localparam int unsigned code_w = 8;

  localparam int unsigned bytes_per_word = 4;

  // Memory size in bytes and the index width it needs
  localparam int unsigned mem_bytes  = 4096;
  localparam int unsigned mem_addr_w = $clog2(mem_bytes);

  // Request operations
  localparam logic [op_w-1:0] op_read   = 8'd0;
  localparam logic [op_w-1:0] op_write  = 8'd1;
  localparam logic [op_w-1:0] op_atomic = 8'd2;

  // Response codes
  localparam logic [code_w-1:0] resp_ok           = 8'd0;
  localparam logic [code_w-1:0] resp_decode_err   = 8'd1;
  localparam logic [code_w-1:0] resp_access_fault = 8'd2;

  // Command kind after decode
  typedef enum logic [1:0] {
    kind_read  = 2'd0,
    kind_write = 2'd1,
    kind_cas   = 2'd2,
    kind_error = 2'd3
  } fabric_kind_e;

  // Halfword pair used by compare-and-swap
  typedef struct packed {
    logic [15:0] desired;
    logic [15:0] expected;
  } fabric_cas_t;

  // Write data is a plain word for writes, a desired/expected pair for the atomic
  typedef union packed {
    logic [data_w-1:0] word;
    fabric_cas_t       cas;
  } fabric_wdata_u;

endpackage : fabric_pkg

`default_nettype wire
